// ==== logic/mdu_pkg.sv ====
// mdu shared definitions
package mdu_pkg;

    // ==================================================
    // widths
    // ==================================================
    localparam int xlen  = 64;
    localparam int op_w  = 8;

    // ==================================================
    // opcodes, any other value gives a zero result
    // ==================================================
    localparam logic [op_w-1:0] op_mul    = 8'h01;
    localparam logic [op_w-1:0] op_mulh   = 8'h02;
    localparam logic [op_w-1:0] op_mulhsu = 8'h03;
    localparam logic [op_w-1:0] op_mulhu  = 8'h04;
    localparam logic [op_w-1:0] op_mulw   = 8'h05;
    localparam logic [op_w-1:0] op_div    = 8'h08;
    localparam logic [op_w-1:0] op_divu   = 8'h09;
    localparam logic [op_w-1:0] op_divw   = 8'h0a;
    localparam logic [op_w-1:0] op_divuw  = 8'h0b;
    localparam logic [op_w-1:0] op_rem    = 8'h0c;
    localparam logic [op_w-1:0] op_remu   = 8'h0d;
    localparam logic [op_w-1:0] op_remw   = 8'h0e;
    localparam logic [op_w-1:0] op_remuw  = 8'h0f;

    // ==================================================
    // sequencing
    // ==================================================
    localparam int iter_n      = 64;               // one result bit per step.
    localparam int cnt_w       = $clog2(iter_n);   // step counter width.
    localparam int mdu_latency = iter_n + 2;       // start edge to done.

endpackage

// ==== logic/mdu_ctrl.sv ====
// mdu operand control
module mdu_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [mdu_pkg::op_w-1:0]     opcode,
    input  logic [mdu_pkg::xlen-1:0]     src_a,
    input  logic [mdu_pkg::xlen-1:0]     src_b,
    input  logic                         mul_done,
    input  logic                         div_done,
    output logic                         busy,
    output logic                         mul_start,
    output logic                         div_start,
    output logic [mdu_pkg::xlen-1:0]     mag_a,
    output logic [mdu_pkg::xlen-1:0]     mag_b,
    output logic                         neg_lo,
    output logic                         neg_hi,
    output logic                         sel_div,
    output logic                         sel_rem,
    output logic                         sel_high,
    output logic                         is_word,
    output logic                         div_zero,
    output logic                         div_ovf,
    output logic [mdu_pkg::xlen-1:0]     src_a_keep
);

    logic                        accept;
    logic                        valid_op;
    logic                        is_div_op;
    logic                        signed_a;
    logic                        signed_b;
    logic                        word_op;
    logic                        rem_op;
    logic                        high_op;
    logic [mdu_pkg::xlen-1:0]    ext_a;
    logic [mdu_pkg::xlen-1:0]    ext_b;
    logic [mdu_pkg::xlen-1:0]    min_neg;
    logic                        neg_a;
    logic                        neg_b;

    assign accept = start & ~busy;

    // ==================================================
    // opcode decode
    // ==================================================
    // columns: valid, div, signed a, signed b, word, rem, high
    always_comb begin
        case (opcode)
            mdu_pkg::op_mul:    {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1000000;
            mdu_pkg::op_mulh:   {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1011001;
            mdu_pkg::op_mulhsu: {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1010001;
            mdu_pkg::op_mulhu:  {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1000001;
            mdu_pkg::op_mulw:   {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1000100;
            mdu_pkg::op_div:    {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1111000;
            mdu_pkg::op_divu:   {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1100000;
            mdu_pkg::op_divw:   {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1111100;
            mdu_pkg::op_divuw:  {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1100100;
            mdu_pkg::op_rem:    {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1111010;
            mdu_pkg::op_remu:   {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1100010;
            mdu_pkg::op_remw:   {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1111110;
            mdu_pkg::op_remuw:  {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b1100110;
            default:            {valid_op, is_div_op, signed_a, signed_b, word_op, rem_op, high_op} = 7'b0000000;
        endcase
    end

    // word ops see only the low half of each source.
    assign ext_a = word_op ? {{32{signed_a & src_a[31]}}, src_a[31:0]} : src_a;
    assign ext_b = word_op ? {{32{signed_b & src_b[31]}}, src_b[31:0]} : src_b;

    assign neg_a   = signed_a & ext_a[mdu_pkg::xlen-1];
    assign neg_b   = signed_b & ext_b[mdu_pkg::xlen-1];
    assign min_neg = word_op ? {{33{1'b1}}, 31'd0} : {1'b1, 63'd0};

    // ==================================================
    // sequencing
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            mul_start <= 1'b0;
            div_start <= 1'b0;
        end else begin
            mul_start <= accept & ~is_div_op;   // no-ops run through the multiplier.
            div_start <= accept & is_div_op;
            if (accept) begin
                busy <= 1'b1;
            end else if (mul_done | div_done) begin
                busy <= 1'b0;
            end
        end
    end

    // operands and flags hold until the next accepted start.
    always_ff @(posedge clk) begin
        if (accept) begin
            mag_a      <= !valid_op ? '0 : (neg_a ? -ext_a : ext_a);
            mag_b      <= neg_b ? -ext_b : ext_b;
            neg_lo     <= neg_a ^ neg_b;        // quotient or product sign.
            neg_hi     <= is_div_op ? neg_a : (neg_a ^ neg_b);
            sel_div    <= is_div_op;
            sel_rem    <= rem_op;
            sel_high   <= high_op;
            is_word    <= word_op;
            div_zero   <= is_div_op & (ext_b == '0);
            div_ovf    <= is_div_op & signed_a & (ext_a == min_neg) & (&ext_b);
            src_a_keep <= ext_a;
        end
    end

endmodule

// ==== logic/mul_iter.sv ====
// iterative shift-add multiplier
module mul_iter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mul_start,
    input  logic [mdu_pkg::xlen-1:0]     mag_a,
    input  logic [mdu_pkg::xlen-1:0]     mag_b,
    output logic [mdu_pkg::xlen-1:0]     prod_hi,
    output logic [mdu_pkg::xlen-1:0]     prod_lo,
    output logic                         mul_done
);

    logic                            active;
    logic [mdu_pkg::cnt_w-1:0]       cnt;
    logic [mdu_pkg::xlen-1:0]        mcand;
    logic [2*mdu_pkg::xlen-1:0]      acc;     // partial product over remaining multiplier bits.
    logic [mdu_pkg::xlen:0]          sum;

    // add multiplicand to the upper half when the current multiplier bit is set.
    assign sum = {1'b0, acc[2*mdu_pkg::xlen-1:mdu_pkg::xlen]}
               + (acc[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            cnt      <= '0;
            mul_done <= 1'b0;
        end else begin
            mul_done <= 1'b0;
            if (mul_start) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (active) begin
                cnt <= cnt + 1'b1;
                if (cnt == mdu_pkg::cnt_w'(mdu_pkg::iter_n - 1)) begin
                    active   <= 1'b0;
                    mul_done <= 1'b1;   // last step lands this edge.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand <= mag_a;
            acc   <= {{mdu_pkg::xlen{1'b0}}, mag_b};
        end else if (active) begin
            acc <= {sum, acc[mdu_pkg::xlen-1:1]};
        end
    end

    assign prod_hi = acc[2*mdu_pkg::xlen-1:mdu_pkg::xlen];
    assign prod_lo = acc[mdu_pkg::xlen-1:0];

endmodule

// ==== logic/div_iter.sv ====
// iterative restoring divider
module div_iter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         div_start,
    input  logic [mdu_pkg::xlen-1:0]     mag_a,
    input  logic [mdu_pkg::xlen-1:0]     mag_b,
    output logic [mdu_pkg::xlen-1:0]     quotient,
    output logic [mdu_pkg::xlen-1:0]     remainder,
    output logic                         div_done
);

    logic                            active;
    logic [mdu_pkg::cnt_w-1:0]       cnt;
    logic [mdu_pkg::xlen-1:0]        dvsr;
    logic [2*mdu_pkg::xlen-1:0]      work;      // remainder above, dividend and quotient below.
    logic [2*mdu_pkg::xlen:0]        shifted;
    logic [2*mdu_pkg::xlen:0]        aligned;
    logic [2*mdu_pkg::xlen:0]        diff;

    // extra top bit keeps the doubled remainder from wrapping.
    assign shifted = {work, 1'b0};
    assign aligned = {1'b0, dvsr, {mdu_pkg::xlen{1'b0}}};
    assign diff    = shifted - aligned;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            cnt      <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                active <= 1'b1;
                cnt    <= '0;
            end else if (active) begin
                cnt <= cnt + 1'b1;
                if (cnt == mdu_pkg::cnt_w'(mdu_pkg::iter_n - 1)) begin
                    active   <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            dvsr <= mag_b;
            work <= {{mdu_pkg::xlen{1'b0}}, mag_a};
        end else if (active) begin
            if (shifted >= aligned) begin
                work <= {diff[2*mdu_pkg::xlen-1:1], 1'b1};   // subtract and set quotient bit.
            end else begin
                work <= shifted[2*mdu_pkg::xlen-1:0];        // restore.
            end
        end
    end

    assign quotient  = work[mdu_pkg::xlen-1:0];
    assign remainder = work[2*mdu_pkg::xlen-1:mdu_pkg::xlen];

endmodule

// ==== logic/result_fmt.sv ====
// mdu result formatter
module result_fmt (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         mul_done,
    input  logic                         div_done,
    input  logic [mdu_pkg::xlen-1:0]     prod_hi,
    input  logic [mdu_pkg::xlen-1:0]     prod_lo,
    input  logic [mdu_pkg::xlen-1:0]     quotient,
    input  logic [mdu_pkg::xlen-1:0]     remainder,
    input  logic                         neg_lo,
    input  logic                         neg_hi,
    input  logic                         sel_div,
    input  logic                         sel_rem,
    input  logic                         sel_high,
    input  logic                         is_word,
    input  logic                         div_zero,
    input  logic                         div_ovf,
    input  logic [mdu_pkg::xlen-1:0]     src_a_keep,
    output logic                         done,
    output logic [mdu_pkg::xlen-1:0]     result
);

    logic                            unit_done;
    logic [2*mdu_pkg::xlen-1:0]      prod_full;
    logic [mdu_pkg::xlen-1:0]        mul_res;
    logic [mdu_pkg::xlen-1:0]        quo_res;
    logic [mdu_pkg::xlen-1:0]        rem_res;
    logic [mdu_pkg::xlen-1:0]        raw_res;
    logic [mdu_pkg::xlen-1:0]        fmt_res;

    assign unit_done = mul_done | div_done;

    // ==================================================
    // multiply path
    // ==================================================
    // the sign goes on the full product so the high half borrows correctly.
    assign prod_full = neg_lo ? -{prod_hi, prod_lo} : {prod_hi, prod_lo};
    assign mul_res   = sel_high ? prod_full[2*mdu_pkg::xlen-1:mdu_pkg::xlen]
                                : prod_full[mdu_pkg::xlen-1:0];

    // ==================================================
    // divide path
    // ==================================================
    always_comb begin
        if (div_zero) begin
            quo_res = '1;                       // all ones on divide by zero.
            rem_res = src_a_keep;
        end else if (div_ovf) begin
            quo_res = src_a_keep;               // most negative / -1.
            rem_res = '0;
        end else begin
            quo_res = neg_lo ? -quotient : quotient;
            rem_res = neg_hi ? -remainder : remainder;
        end
    end

    assign raw_res = !sel_div ? mul_res : (sel_rem ? rem_res : quo_res);
    assign fmt_res = is_word ? {{32{raw_res[31]}}, raw_res[31:0]} : raw_res;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= unit_done;
            if (unit_done) begin
                result <= fmt_res;              // held until the next done.
            end
        end
    end

endmodule

// ==== logic/mdu_top.sv ====
// rv64m multiply/divide unit
module mdu_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic [mdu_pkg::op_w-1:0]     opcode,
    input  logic [mdu_pkg::xlen-1:0]     src_a,
    input  logic [mdu_pkg::xlen-1:0]     src_b,
    output logic                         busy,
    output logic                         done,
    output logic [mdu_pkg::xlen-1:0]     result
);

    logic                        mul_start;
    logic                        div_start;
    logic                        mul_done;
    logic                        div_done;
    logic [mdu_pkg::xlen-1:0]    mag_a;
    logic [mdu_pkg::xlen-1:0]    mag_b;
    logic [mdu_pkg::xlen-1:0]    prod_hi;
    logic [mdu_pkg::xlen-1:0]    prod_lo;
    logic [mdu_pkg::xlen-1:0]    quotient;
    logic [mdu_pkg::xlen-1:0]    remainder;
    logic                        neg_lo;
    logic                        neg_hi;
    logic                        sel_div;
    logic                        sel_rem;
    logic                        sel_high;
    logic                        is_word;
    logic                        div_zero;
    logic                        div_ovf;
    logic [mdu_pkg::xlen-1:0]    src_a_keep;

    // ==================================================
    // control and operand preparation
    // ==================================================
    mdu_ctrl mdu_ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .opcode     (opcode),
        .src_a      (src_a),
        .src_b      (src_b),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .busy       (busy),
        .mul_start  (mul_start),
        .div_start  (div_start),
        .mag_a      (mag_a),
        .mag_b      (mag_b),
        .neg_lo     (neg_lo),
        .neg_hi     (neg_hi),
        .sel_div    (sel_div),
        .sel_rem    (sel_rem),
        .sel_high   (sel_high),
        .is_word    (is_word),
        .div_zero   (div_zero),
        .div_ovf    (div_ovf),
        .src_a_keep (src_a_keep)
    );

    // ==================================================
    // iterative units
    // ==================================================
    mul_iter mul_iter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mul_start (mul_start),
        .mag_a     (mag_a),
        .mag_b     (mag_b),
        .prod_hi   (prod_hi),
        .prod_lo   (prod_lo),
        .mul_done  (mul_done)
    );

    div_iter div_iter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .div_start (div_start),
        .mag_a     (mag_a),
        .mag_b     (mag_b),
        .quotient  (quotient),
        .remainder (remainder),
        .div_done  (div_done)
    );

    result_fmt result_fmt_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .prod_hi    (prod_hi),
        .prod_lo    (prod_lo),
        .quotient   (quotient),
        .remainder  (remainder),
        .neg_lo     (neg_lo),
        .neg_hi     (neg_hi),
        .sel_div    (sel_div),
        .sel_rem    (sel_rem),
        .sel_high   (sel_high),
        .is_word    (is_word),
        .div_zero   (div_zero),
        .div_ovf    (div_ovf),
        .src_a_keep (src_a_keep),
        .done       (done),
        .result     (result)
    );

endmodule

// ==== verif/mdu_chk.sv ====
// mdu timing checker
module mdu_chk (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         start,
    input  logic                         busy,
    input  logic                         done,
    input  logic [mdu_pkg::xlen-1:0]     result
);
    timeunit 1ns;
    timeprecision 1ps;

    int   fail_cnt = 0;
    logic run;
    int   age;

    // cycles since the last accepted start.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run <= 1'b0;
            age <= 0;
        end else if (start && !busy) begin
            run <= 1'b1;
            age <= 0;
        end else if (run) begin
            age <= age + 1;
            if (done) begin
                run <= 1'b0;
            end
        end
    end

    // ==================================================
    // assertions
    // ==================================================
    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !busy && !done && result == '0)
        else begin fail_cnt++; $error("unit not idle after reset"); end

    a_busy_run: assert property (@(posedge clk) disable iff (!rst_n)
        run && age < mdu_pkg::mdu_latency |-> busy && !done)
        else begin fail_cnt++; $error("busy dropped or done early"); end

    a_done_time: assert property (@(posedge clk) disable iff (!rst_n)
        run && age == mdu_pkg::mdu_latency |-> done && !busy)
        else begin fail_cnt++; $error("done missing at fixed latency"); end

    // catches a done caused by a start given while busy.
    a_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> run && age == mdu_pkg::mdu_latency)
        else begin fail_cnt++; $error("done without an accepted start"); end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin fail_cnt++; $error("done longer than one cycle"); end

    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(result) |-> done)
        else begin fail_cnt++; $error("result changed outside done"); end

    a_busy_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> done)
        else begin fail_cnt++; $error("busy fell without done"); end

endmodule

bind mdu_top mdu_chk mdu_chk_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .start  (start),
    .busy   (busy),
    .done   (done),
    .result (result)
);

// ==== verif/mdu_tb.sv ====
// mdu testbench
module mdu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int corner_n  = 7;
    localparam int rand_n    = 20;
    localparam int op_n      = 13;
    localparam int total_ops = op_n * (corner_n * corner_n + rand_n);
    localparam int run_ns    = total_ops * (mdu_pkg::mdu_latency + 4) * 40 + 3 * 40;

    logic                        clk;
    logic                        rst_n;
    logic                        start;
    logic [mdu_pkg::op_w-1:0]    opcode;
    logic [mdu_pkg::xlen-1:0]    src_a;
    logic [mdu_pkg::xlen-1:0]    src_b;
    logic                        busy;
    logic                        done;
    logic [mdu_pkg::xlen-1:0]    result;

    int                          err_cnt;
    int                          op_cnt;
    int                          seed;
    logic [mdu_pkg::op_w-1:0]    op_list [op_n];
    logic [mdu_pkg::xlen-1:0]    corners [corner_n];

    mdu_top mdu_top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .opcode (opcode),
        .src_a  (src_a),
        .src_b  (src_b),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // ==================================================
    // reference model, rv64m rules
    // ==================================================
    function automatic logic [63:0] sext_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic [63:0] model(input logic [7:0] op, input logic [63:0] a,
                                          input logic [63:0] b);
        logic signed [127:0] sa;
        logic signed [127:0] sb;
        logic signed [127:0] ub;
        logic [127:0]        prod;
        logic signed [63:0]  sa64;
        logic signed [63:0]  sb64;
        logic signed [31:0]  wa;
        logic signed [31:0]  wb;
        logic                ovf64;
        logic                ovfw;
        sa    = {{64{a[63]}}, a};
        sb    = {{64{b[63]}}, b};
        ub    = {64'd0, b};
        sa64  = a;
        sb64  = b;
        wa    = a[31:0];
        wb    = b[31:0];
        ovf64 = (a == {1'b1, 63'd0}) && (b == '1);
        ovfw  = (wa == 32'h8000_0000) && (wb == 32'hffff_ffff);
        case (op)
            mdu_pkg::op_mul:    return a * b;
            mdu_pkg::op_mulh:   prod = sa * sb;
            mdu_pkg::op_mulhsu: prod = sa * ub;
            mdu_pkg::op_mulhu:  prod = {64'd0, a} * {64'd0, b};
            mdu_pkg::op_mulw:   return sext_word(32'(a * b));
            mdu_pkg::op_div:    return (b == '0) ? '1 : (ovf64 ? a : $unsigned(sa64 / sb64));
            mdu_pkg::op_divu:   return (b == '0) ? '1 : a / b;
            mdu_pkg::op_divw:   return (wb == '0) ? '1 : sext_word(ovfw ? wa : wa / wb);
            mdu_pkg::op_divuw:  return (wb == '0) ? '1 : sext_word(a[31:0] / b[31:0]);
            mdu_pkg::op_rem:    return (b == '0) ? a : (ovf64 ? '0 : $unsigned(sa64 % sb64));
            mdu_pkg::op_remu:   return (b == '0) ? a : a % b;
            mdu_pkg::op_remw:   return (wb == '0) ? sext_word(wa) : (ovfw ? '0 : sext_word(wa % wb));
            mdu_pkg::op_remuw:  return (wb == '0) ? sext_word(wa) : sext_word(a[31:0] % b[31:0]);
            default:            return '0;
        endcase
        return prod[127:64];    // the three high-half multiplies.
    endfunction

    // one operation, optionally with a stray start while busy.
    task automatic run_op(input logic [7:0] op, input logic [63:0] a, input logic [63:0] b,
                          input bit poke);
        logic [63:0] exp;
        int          cycles;
        exp    = model(op, a, b);
        start  = 1'b1;
        opcode = op;
        src_a  = a;
        src_b  = b;
        @(posedge clk);
        #2;
        start  = 1'b0;
        cycles = 0;
        while (!done) begin
            @(posedge clk);
            #2;
            cycles++;
            start = poke && (cycles == 20);
            if (start) begin
                src_a = ~a;
            end
        end
        op_cnt++;
        if (result !== exp) begin
            err_cnt++;
            $display("mismatch at %0t: result expected %h actual %h (opcode %h src_a %h src_b %h)",
                     $time, exp, result, op, a, b);
        end
    endtask

    // ==================================================
    // stimulus
    // ==================================================
    initial begin
        logic [63:0] ra;
        logic [63:0] rb;
        int unsigned sh;
        seed    = 32822;
        err_cnt = 0;
        op_cnt  = 0;
        rst_n   = 1'b0;
        start   = 1'b0;
        opcode  = '0;
        src_a   = '0;
        src_b   = '0;
        op_list = '{mdu_pkg::op_mul, mdu_pkg::op_mulh, mdu_pkg::op_mulhsu, mdu_pkg::op_mulhu,
                    mdu_pkg::op_mulw, mdu_pkg::op_div, mdu_pkg::op_divu, mdu_pkg::op_divw,
                    mdu_pkg::op_divuw, mdu_pkg::op_rem, mdu_pkg::op_remu, mdu_pkg::op_remw,
                    mdu_pkg::op_remuw};
        corners = '{64'd0, 64'd1, '1, {1'b1, 63'd0}, {1'b0, {63{1'b1}}},
                    64'hffff_ffff_8000_0000, 64'h5555_5555_ffff_ffff};
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;
        foreach (op_list[i]) begin
            foreach (corners[j]) begin
                foreach (corners[k]) begin
                    run_op(op_list[i], corners[j], corners[k], ((j + k) % 5) == 0);
                end
            end
        end
        foreach (op_list[i]) begin
            repeat (rand_n) begin
                ra = {$random(seed), $random(seed)};
                rb = {$random(seed), $random(seed)};
                sh = $unsigned($random(seed)) % 64;
                run_op(op_list[i], ra, rb >> sh, 1'b0);   // varied divisor sizes.
            end
        end
        $display("errors: %0d value mismatches, %0d assertion failures, %0d operations run",
                 err_cnt, mdu_top_i.mdu_chk_i.fail_cnt, op_cnt);
        if (err_cnt == 0 && mdu_top_i.mdu_chk_i.fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(run_ns);
        $display("timeout: the operations did not complete within %0d ns", run_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
logic/mdu_pkg.sv
logic/mdu_ctrl.sv
logic/mul_iter.sv
logic/div_iter.sv
logic/result_fmt.sv
logic/mdu_top.sv
verif/mdu_chk.sv
verif/mdu_tb.sv

// ==== run.sh ====
#!/bin/sh
# verilator build and run of the mdu testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module mdu_tb -f flist.f -o mdu_sim > build.log 2>&1 \
    && ./obj_dir/mdu_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || echo "SIMULATION FAILED" >> sim.log
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
